// File: booth_pkg.sv
package booth_pkg;

	localparam int SIZE = 8;                      // operand width
	localparam int HI_WIDTH = SIZE + 1;           // high accumulator and adder width
	localparam int PRODUCT_WIDTH = 2 * SIZE;
	localparam int STEPS = SIZE / 2;              // radix-4 iterations
	localparam int STEP_COUNT_WIDTH = 3;
	localparam int LATENCY = 3 * STEPS + 2;       // start sample to done, in cycles

	// one adder action, chosen from the booth triplet
	typedef struct packed {
		logic enable;    // capture result this cycle
		logic subtract;  // hi - operand
		logic double;    // operand is 2M
		logic zero;      // pass hi through
	} adder_op_t;

	// every strobe from the controller into the datapath
	typedef struct packed {
		logic hi_load;
		logic hi_shift;
		logic hi_clear;
		logic lo_load;
		logic lo_shift;
		logic lo_clear;
		logic m_enable;
		logic x_enable;
		logic x_clear;
		adder_op_t adder;
	} datapath_ctrl_t;

endpackage

// File: booth_adder.sv
`timescale 1ns/1ns

module booth_adder
	import booth_pkg::*;
(
	input  logic                clock,
	input  logic                reset,
	input  adder_op_t           op,
	input  logic [SIZE-1:0]     m,
	input  logic [HI_WIDTH-1:0] hi,
	output logic [HI_WIDTH-1:0] out
);

	logic [HI_WIDTH-1:0] m_ext;
	logic [HI_WIDTH-1:0] operand;
	logic [HI_WIDTH-1:0] result;

	assign m_ext = {m[SIZE-1], m};  // sign extend to accumulator width

	always_comb begin
		operand = m_ext;
		if (op.double) begin
			operand = {m, 1'b0};  // 2M, still fits HI_WIDTH
		end
		if (op.zero) begin
			result = hi;
		end else if (op.subtract) begin
			result = hi - operand;
		end else begin
			result = hi + operand;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out <= '0;
		end else if (op.enable) begin
			out <= result;
		end
	end

endmodule

// File: booth_shift_register.sv
`timescale 1ns/1ns

module booth_shift_register
	import booth_pkg::*;
#(
	parameter int WIDTH = SIZE
)
(
	input  logic             clock,
	input  logic             reset,
	input  logic             clear,
	input  logic             load,
	input  logic             shift,
	input  logic [1:0]       serial_in,
	input  logic [WIDTH-1:0] parallel_in,
	output logic [1:0]       serial_out,
	output logic [WIDTH-1:0] parallel_out
);

	logic [WIDTH-1:0] shifted;

	// two places right, new bits enter at the top
	assign shifted = {serial_in, parallel_out[WIDTH-1:2]};

	// the bits that leave on the next shift
	assign serial_out = parallel_out[1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			parallel_out <= '0;
		end else if (clear) begin
			parallel_out <= '0;
		end else if (load) begin
			parallel_out <= parallel_in;
		end else if (shift) begin
			parallel_out <= shifted;
		end
	end

endmodule

// File: booth_datapath.sv
`timescale 1ns/1ns

module booth_datapath
	import booth_pkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic [SIZE-1:0]          a,
	input  logic [SIZE-1:0]          b,
	input  datapath_ctrl_t           ctrl,
	output logic [PRODUCT_WIDTH-1:0] product,
	output logic [2:0]               recode
);

	logic [SIZE-1:0]     m_q;
	logic                x_q;
	logic [HI_WIDTH-1:0] adder_out;
	logic [HI_WIDTH-1:0] hi_q;
	logic [SIZE-1:0]     lo_q;
	logic [1:0]          hi_serial_out;
	logic [1:0]          lo_serial_out;
	logic                hi_sign;

	// multiplicand
	always_ff @(posedge clock) begin
		if (reset) begin
			m_q <= '0;
		end else if (ctrl.m_enable) begin
			m_q <= b;
		end
	end

	// last multiplier bit shifted out of LO
	always_ff @(posedge clock) begin
		if (reset) begin
			x_q <= 1'b0;
		end else if (ctrl.x_clear) begin
			x_q <= 1'b0;
		end else if (ctrl.x_enable) begin
			x_q <= lo_serial_out[1];
		end
	end

	booth_adder i_booth_adder (
		.clock (clock),
		.reset (reset),
		.op    (ctrl.adder),
		.m     (m_q),
		.hi    (hi_q),
		.out   (adder_out)
	);

	// -2M with M = -128 gives +256, which wraps to 1_0000_0000.
	// no other sum lands on that pattern, so treat it as positive
	assign hi_sign = hi_q[HI_WIDTH-1] & (|hi_q[HI_WIDTH-2:0]);

	booth_shift_register #(
		.WIDTH (HI_WIDTH)
	) i_shift_hi (
		.clock        (clock),
		.reset        (reset),
		.clear        (ctrl.hi_clear),
		.load         (ctrl.hi_load),
		.shift        (ctrl.hi_shift),
		.serial_in    ({hi_sign, hi_sign}),  // arithmetic shift
		.parallel_in  (adder_out),
		.serial_out   (hi_serial_out),
		.parallel_out (hi_q)
	);

	booth_shift_register #(
		.WIDTH (SIZE)
	) i_shift_lo (
		.clock        (clock),
		.reset        (reset),
		.clear        (ctrl.lo_clear),
		.load         (ctrl.lo_load),
		.shift        (ctrl.lo_shift),
		.serial_in    (hi_serial_out),  // low bits of HI move into LO
		.parallel_in  (a),
		.serial_out   (lo_serial_out),
		.parallel_out (lo_q)
	);

	assign product = {hi_q[SIZE-1:0], lo_q};
	assign recode = {lo_serial_out, x_q};

endmodule

// File: booth_controller.sv
`timescale 1ns/1ns

module booth_controller
	import booth_pkg::*;
(
	input  logic           clock,
	input  logic           reset,
	input  logic           start,
	input  logic [2:0]     recode,
	output datapath_ctrl_t ctrl,
	output logic           busy,
	output logic           done
);

	typedef enum logic [2:0] {IDLE, LOAD, ADD, WRITE, SHIFT, DONE} state_t;

	state_t                      state;
	state_t                      state_next;
	logic [STEP_COUNT_WIDTH-1:0] step_count;
	logic                        last_step;

	assign last_step = (step_count == STEP_COUNT_WIDTH'(STEPS - 1));

	always_comb begin
		state_next = state;
		case (state)
			IDLE:    if (start) state_next = LOAD;  // start ignored elsewhere
			LOAD:    state_next = ADD;
			ADD:     state_next = WRITE;
			WRITE:   state_next = SHIFT;
			SHIFT:   state_next = last_step ? DONE : ADD;
			DONE:    state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			step_count <= '0;
		end else begin
			state <= state_next;
			if (state == LOAD) begin
				step_count <= '0;
			end else if (state == SHIFT) begin
				step_count <= step_count + 1'b1;
			end
		end
	end

	always_comb begin
		ctrl = '0;
		case (state)
			LOAD: begin
				ctrl.lo_load = 1'b1;
				ctrl.m_enable = 1'b1;
				ctrl.hi_clear = 1'b1;
				ctrl.x_clear = 1'b1;
			end
			ADD: begin
				ctrl.adder.enable = 1'b1;
				case (recode)
					3'b000, 3'b111: ctrl.adder.zero = 1'b1;
					3'b011:         ctrl.adder.double = 1'b1;   // +2M
					3'b100: begin
						ctrl.adder.subtract = 1'b1;  // -2M
						ctrl.adder.double = 1'b1;
					end
					3'b101, 3'b110: ctrl.adder.subtract = 1'b1;
					default:        ;                           // +M
				endcase
			end
			WRITE: ctrl.hi_load = 1'b1;
			SHIFT: begin
				ctrl.hi_shift = 1'b1;
				ctrl.lo_shift = 1'b1;
				ctrl.x_enable = 1'b1;
			end
			default: ;
		endcase
	end

	assign busy = (state != IDLE);
	assign done = (state == DONE);

endmodule

// File: booth_multiplier.sv
`timescale 1ns/1ns

module booth_multiplier
	import booth_pkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     start,
	input  logic [SIZE-1:0]          a,        // multiplier
	input  logic [SIZE-1:0]          b,        // multiplicand
	output logic [PRODUCT_WIDTH-1:0] product,
	output logic                     busy,
	output logic                     done
);

	datapath_ctrl_t ctrl;
	logic [2:0]     recode;

	booth_controller i_booth_controller (
		.clock  (clock),
		.reset  (reset),
		.start  (start),
		.recode (recode),
		.ctrl   (ctrl),
		.busy   (busy),
		.done   (done)
	);

	booth_datapath i_booth_datapath (
		.clock   (clock),
		.reset   (reset),
		.a       (a),
		.b       (b),
		.ctrl    (ctrl),
		.product (product),
		.recode  (recode)
	);

endmodule

// File: booth_assert.sv
`timescale 1ns/1ns

module booth_assert
	import booth_pkg::*;
(
	input logic                     clock,
	input logic                     reset,
	input logic                     start,
	input logic [SIZE-1:0]          a,
	input logic [SIZE-1:0]          b,
	input logic [PRODUCT_WIDTH-1:0] product,
	input logic                     busy,
	input logic                     done
);

	int error_count = 0;  // read by the testbench at the end

	logic                            accepted;
	logic                            started;
	logic [SIZE-1:0]                 captured_a;
	logic [SIZE-1:0]                 captured_b;
	logic signed [PRODUCT_WIDTH-1:0] wide_a;
	logic signed [PRODUCT_WIDTH-1:0] wide_b;
	logic [PRODUCT_WIDTH-1:0]        expected_product;

	assign accepted = start && !busy;  // start only counts while idle

	// operands of the product in flight
	always_ff @(posedge clock) begin
		if (reset) begin
			captured_a <= '0;
			captured_b <= '0;
			started <= 1'b0;
		end else if (accepted) begin
			captured_a <= a;
			captured_b <= b;
			started <= 1'b1;
		end
	end

	assign wide_a = PRODUCT_WIDTH'($signed(captured_a));  // sign extended to product width
	assign wide_b = PRODUCT_WIDTH'($signed(captured_b));
	assign expected_product = wide_a * wide_b;

	product_check: assert property (@(posedge clock) disable iff (reset)
		done |-> product == expected_product)
	else begin
		$error("FAILED product: got %h, expected %h", product, expected_product);
		error_count = error_count + 1;
	end

	// done exactly LATENCY edges after an accepted start and never otherwise
	latency_check: assert property (@(posedge clock) disable iff (reset)
		done == $past(accepted, LATENCY))
	else begin
		$error("done did not come exactly %0d cycles after an accepted start", LATENCY);
		error_count = error_count + 1;
	end

	busy_rise_check: assert property (@(posedge clock) disable iff (reset)
		accepted |=> busy)
	else begin
		$error("busy did not rise after start was accepted");
		error_count = error_count + 1;
	end

	busy_hold_check: assert property (@(posedge clock) disable iff (reset)
		busy && !done |=> busy)
	else begin
		$error("busy dropped before done");
		error_count = error_count + 1;
	end

	busy_fall_check: assert property (@(posedge clock) disable iff (reset)
		done |=> !busy)
	else begin
		$error("busy still high on the cycle after done");
		error_count = error_count + 1;
	end

	busy_idle_check: assert property (@(posedge clock) disable iff (reset)
		!busy && !start |=> !busy)
	else begin
		$error("busy rose without a start");
		error_count = error_count + 1;
	end

	done_busy_check: assert property (@(posedge clock) disable iff (reset)
		done |-> busy)
	else begin
		$error("done high while busy was low");
		error_count = error_count + 1;
	end

	// nothing moves between reset and the first accepted start
	reset_state_check: assert property (@(posedge clock) disable iff (reset)
		!started |-> !busy && !done && product == '0)
	else begin
		$error("FAILED reset state: busy %h, done %h, product %h", busy, done, product);
		error_count = error_count + 1;
	end

endmodule

bind booth_multiplier booth_assert i_booth_assert (
	.clock   (clock),
	.reset   (reset),
	.start   (start),
	.a       (a),
	.b       (b),
	.product (product),
	.busy    (busy),
	.done    (done)
);

// File: booth_tb.sv
`timescale 1ns/1ns

module booth_tb
	import booth_pkg::*;
;

	logic                     clock;
	logic                     reset;
	logic                     start;
	logic [SIZE-1:0]          a;
	logic [SIZE-1:0]          b;
	logic [PRODUCT_WIDTH-1:0] product;
	logic                     busy;
	logic                     done;

	int other_errors = 0;
	int num_directed = 7;
	int num_random = 200;
	int num_burst = 1;

	booth_multiplier i_booth_multiplier (
		.clock   (clock),
		.reset   (reset),
		.start   (start),
		.a       (a),
		.b       (b),
		.product (product),
		.busy    (busy),
		.done    (done)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// one start pulse, operands held until the next product
	task automatic start_product(input logic [SIZE-1:0] x, input logic [SIZE-1:0] y);
		@(posedge clock);
		start <= 1'b1;
		a <= x;
		b <= y;
		@(posedge clock);
		start <= 1'b0;
	endtask

	// returns at the falling edge inside the done cycle
	task automatic wait_for_done();
		int cycles;
		int limit;
		cycles = 0;
		limit = 4 * LATENCY;
		do begin
			@(negedge clock);
			cycles = cycles + 1;
		end while (!done && cycles < limit);
		if (!done) begin
			$display("no done within %0d cycles of the start pulse", limit);
			other_errors = other_errors + 1;
		end
	endtask

	task automatic run_product(input logic [SIZE-1:0] x, input logic [SIZE-1:0] y);
		start_product(x, y);
		wait_for_done();
	endtask

	task automatic run_directed();
		run_product(8'h00, 8'h00);
		run_product(8'h01, 8'h01);
		run_product(8'hff, 8'hff);  // -1 x -1
		run_product(8'h80, 8'h80);  // -128 x -128, the -2M corner
		run_product(8'h80, 8'h7f);  // -128 x 127
		run_product(8'h7f, 8'h7f);
		run_product(8'h05, 8'hfd);  // 5 x -3
	endtask

	task automatic run_random(input int count);
		logic [SIZE-1:0] x;
		logic [SIZE-1:0] y;
		int gap;
		for (int i = 0; i < count; i++) begin
			x = SIZE'($urandom);
			y = SIZE'($urandom);
			gap = $urandom_range(0, 3);  // some products start back to back
			repeat (gap) @(posedge clock);
			run_product(x, y);
		end
	endtask

	// start pulses with fresh operands while a product is running
	task automatic run_busy_burst();
		logic [SIZE-1:0] x;
		logic [SIZE-1:0] y;
		x = SIZE'($urandom);
		y = SIZE'($urandom);
		start_product(x, y);
		repeat (2) @(posedge clock);  // LOAD has taken a and b by now
		for (int i = 0; i < 5; i++) begin
			@(posedge clock);
			start <= 1'b1;
			a <= SIZE'($urandom);
			b <= SIZE'($urandom);
			@(posedge clock);
			start <= 1'b0;
		end
		wait_for_done();
	endtask

	task automatic finish_run();
		int assert_errors;
		int total;
		assert_errors = i_booth_multiplier.i_booth_assert.error_count;
		total = assert_errors + other_errors;
		$display("errors: %0d from assertions, %0d other, %0d total",
			assert_errors, other_errors, total);
		if (total == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		a = '0;
		b = '0;
		void'($urandom(32'h23d4819b));
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		repeat (3) @(posedge clock);  // idle stretch after reset
		run_directed();
		run_random(num_random);
		run_busy_burst();
		repeat (4) @(posedge clock);
		finish_run();
	end

	// 1.5 times the expected run length plus the reset stretch
	initial begin
		int products;
		int limit_cycles;
		products = num_directed + num_random + num_burst;
		limit_cycles = 3 * products * (LATENCY + 4) / 2 + 20;
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		other_errors = other_errors + 1;
		finish_run();
	end

endmodule

// File: list.f
booth_pkg.sv
booth_adder.sv
booth_shift_register.sv
booth_datapath.sv
booth_controller.sv
booth_multiplier.sv
booth_assert.sv
booth_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the booth multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -f list.f --top-module booth_tb -o booth_sim

# a high error limit lets the run reach its own closing report
./obj_dir/booth_sim +verilator+error+limit+100000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
